// File: Bender.yml
package:
  name: ooo_core

sources:
  - ooo_pkg.sv
  - dispatch_rename.sv
  - reservation_station.sv
  - alu_unit.sv
  - mult_pipe.sv
  - completion_bus.sv
  - reorder_buffer.sv
  - register_file.sv
  - ooo_core.sv
  - target: simulation
    files:
      - tb_ooo_core.sv

// File: alu_unit.sv
`timescale 1ns/1ps

module alu_unit
    import ooo_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  rs_entry_t issue,
    output logic      issue_ready,
    output logic      done_valid,
    output cdb_t      done,
    input  logic      grant
);

    data_t    a;
    data_t    b;
    data_t    result;
    logic     full_q;
    rob_tag_t tag_q;
    data_t    value_q;

    assign a = issue.src1.word.value;
    assign b = issue.src2.word.value;

    always_comb begin
        case (issue.op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_sltu: result = {{(xlen-1){1'b0}}, a < b};
            default: result = '0;
        endcase
    end

    // output register frees up as the bus takes it
    assign issue_ready = !full_q || grant;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (issue_ready) begin
            full_q <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid && issue_ready) begin
            tag_q   <= issue.tag;
            value_q <= result;
        end
    end

    assign done_valid  = full_q;
    assign done.valid  = full_q;
    assign done.tag    = tag_q;
    assign done.value  = value_q;

endmodule

// File: completion_bus.sv
`timescale 1ns/1ps

module completion_bus
    import ooo_pkg::*;
(
    input  logic mul_valid,
    input  cdb_t mul_done,
    input  logic alu_valid,
    input  cdb_t alu_done,
    output logic mul_grant,
    output logic alu_grant,
    output cdb_t cdb
);

    // multiplier first, it stalls a deeper pipe
    assign mul_grant = mul_valid;
    assign alu_grant = alu_valid && !mul_valid;

    always_comb begin
        if (mul_grant) begin
            cdb = mul_done;
        end else begin
            cdb = alu_done;
        end
        cdb.valid = mul_grant || alu_grant;
    end

endmodule

// File: dispatch_rename.sv
`timescale 1ns/1ps

module dispatch_rename
    import ooo_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  uop_t                 in_uop,
    output logic                 in_ready,
    input  logic                 alu_full,
    input  logic                 mul_full,
    input  logic                 rob_full,
    input  rob_tag_t             rob_tail,
    input  logic [rob_size-1:0]  rob_done,
    input  data_t [rob_size-1:0] rob_value,
    input  data_t [1:0]          src_value,
    input  logic [1:0]           src_busy,
    input  rob_tag_t [1:0]       src_tag,
    input  cdb_t                 cdb,
    output logic                 alu_load,
    output logic                 mul_load,
    output rs_entry_t            rs_entry,
    output logic                 alloc,
    output reg_idx_t             alloc_dest
);

    logic is_mul;
    logic take;

    // try the regfile, the ROB and the bus in turn before waiting on the tag
    function automatic operand_t resolve(
        input data_t    reg_val,
        input logic     busy,
        input rob_tag_t tag,
        input logic     done,
        input data_t    done_val,
        input cdb_t     bus
    );
        operand_t o;
        o.ready = 1'b1;
        o.word.value = reg_val;
        if (busy) begin
            if (done) begin
                o.word.value = done_val;
            end else if (bus.valid && bus.tag == tag) begin
                o.word.value = bus.value;
            end else begin
                o.ready = 1'b0;
                o.word.pending.pad = '0;
                o.word.pending.tag = tag;
            end
        end
        return o;
    endfunction

    // station is picked by op alone
    assign is_mul   = (in_uop.op == op_mul);
    assign in_ready = !rob_full && (is_mul ? !mul_full : !alu_full);
    assign take     = in_valid && in_ready;

    assign alu_load   = take && !is_mul;
    assign mul_load   = take && is_mul;
    assign alloc      = take;
    assign alloc_dest = in_uop.dest;

    always_comb begin
        rs_entry.op   = in_uop.op;
        rs_entry.tag  = rob_tail;
        rs_entry.src1 = resolve(src_value[0], src_busy[0], src_tag[0],
                                rob_done[src_tag[0]], rob_value[src_tag[0]], cdb);
        if (in_uop.use_imm) begin
            // immediate always replaces source 2
            rs_entry.src2.ready      = 1'b1;
            rs_entry.src2.word.value = in_uop.imm;
        end else begin
            rs_entry.src2 = resolve(src_value[1], src_busy[1], src_tag[1],
                                    rob_done[src_tag[1]], rob_value[src_tag[1]], cdb);
        end
    end

endmodule

// File: mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe
    import ooo_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  rs_entry_t issue,
    output logic      issue_ready,
    output logic      done_valid,
    output cdb_t      done,
    input  logic      grant
);

    logic [mult_stages-1:0]     valid_q;
    rob_tag_t [mult_stages-1:0] tag_q;
    logic                       advance;

    // stage 1 operands
    data_t       a_q;
    data_t       b_q;
    // stage 2 partial products, low word only
    data_t       part_lo_q;
    logic [15:0] part_hi_q;
    // stage 3 sum
    data_t       prod_q;

    // whole pipe moves together, held while the last stage waits
    assign advance     = !valid_q[mult_stages-1] || grant;
    assign issue_ready = advance;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[mult_stages-2:0], issue_valid};
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            tag_q     <= {tag_q[mult_stages-2:0], issue.tag};
            a_q       <= issue.src1.word.value;
            b_q       <= issue.src2.word.value;
            part_lo_q <= a_q * {16'b0, b_q[15:0]};
            // upper half only reaches bits 31..16
            part_hi_q <= 16'(a_q[15:0] * b_q[31:16]);
            prod_q    <= part_lo_q + {part_hi_q, 16'b0};
        end
    end

    assign done_valid = valid_q[mult_stages-1];
    assign done.valid = valid_q[mult_stages-1];
    assign done.tag   = tag_q[mult_stages-1];
    assign done.value = prod_q;

endmodule

// File: ooo_core.f
ooo_pkg.sv
dispatch_rename.sv
reservation_station.sv
alu_unit.sv
mult_pipe.sv
completion_bus.sv
reorder_buffer.sv
register_file.sv
ooo_core.sv
tb_ooo_core.sv

// File: ooo_core.sv
`timescale 1ns/1ps

module ooo_core
    import ooo_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    input  logic    in_valid,
    input  uop_t    in_uop,
    output logic    in_ready,
    output logic    commit_valid,
    output commit_t commit
);

    // dispatch side
    logic                alu_load;
    logic                mul_load;
    logic                alu_full;
    logic                mul_full;
    rs_entry_t           rs_entry;
    logic                alloc;
    reg_idx_t            alloc_dest;
    logic                rob_full;
    rob_tag_t            rob_tail;
    logic [rob_size-1:0] rob_done;
    data_t [rob_size-1:0] rob_value;
    data_t [1:0]         src_value;
    logic [1:0]          src_busy;
    rob_tag_t [1:0]      src_tag;

    // issue and completion
    logic      alu_issue_valid;
    logic      alu_issue_ready;
    rs_entry_t alu_issue;
    logic      mul_issue_valid;
    logic      mul_issue_ready;
    rs_entry_t mul_issue;
    logic      alu_done_valid;
    cdb_t      alu_done;
    logic      alu_grant;
    logic      mul_done_valid;
    cdb_t      mul_done;
    logic      mul_grant;
    cdb_t      cdb;

    //////////////////////////////////////////////////////////////////////
    // dispatch and rename
    //////////////////////////////////////////////////////////////////////

    dispatch_rename u_dispatch (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .in_ready   (in_ready),
        .alu_full   (alu_full),
        .mul_full   (mul_full),
        .rob_full   (rob_full),
        .rob_tail   (rob_tail),
        .rob_done   (rob_done),
        .rob_value  (rob_value),
        .src_value  (src_value),
        .src_busy   (src_busy),
        .src_tag    (src_tag),
        .cdb        (cdb),
        .alu_load   (alu_load),
        .mul_load   (mul_load),
        .rs_entry   (rs_entry),
        .alloc      (alloc),
        .alloc_dest (alloc_dest)
    );

    //////////////////////////////////////////////////////////////////////
    // stations and units
    //////////////////////////////////////////////////////////////////////

    reservation_station u_rs_alu (
        .clock       (clock),
        .rst_n       (rst_n),
        .load        (alu_load),
        .entry_in    (rs_entry),
        .full        (alu_full),
        .cdb         (cdb),
        .issue_valid (alu_issue_valid),
        .issue       (alu_issue),
        .issue_ready (alu_issue_ready)
    );

    reservation_station u_rs_mul (
        .clock       (clock),
        .rst_n       (rst_n),
        .load        (mul_load),
        .entry_in    (rs_entry),
        .full        (mul_full),
        .cdb         (cdb),
        .issue_valid (mul_issue_valid),
        .issue       (mul_issue),
        .issue_ready (mul_issue_ready)
    );

    alu_unit u_alu (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue_valid (alu_issue_valid),
        .issue       (alu_issue),
        .issue_ready (alu_issue_ready),
        .done_valid  (alu_done_valid),
        .done        (alu_done),
        .grant       (alu_grant)
    );

    mult_pipe u_mul (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue_valid (mul_issue_valid),
        .issue       (mul_issue),
        .issue_ready (mul_issue_ready),
        .done_valid  (mul_done_valid),
        .done        (mul_done),
        .grant       (mul_grant)
    );

    completion_bus u_cdb (
        .mul_valid (mul_done_valid),
        .mul_done  (mul_done),
        .alu_valid (alu_done_valid),
        .alu_done  (alu_done),
        .mul_grant (mul_grant),
        .alu_grant (alu_grant),
        .cdb       (cdb)
    );

    //////////////////////////////////////////////////////////////////////
    // in-order retirement
    //////////////////////////////////////////////////////////////////////

    reorder_buffer u_rob (
        .clock        (clock),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .alloc_dest   (alloc_dest),
        .rob_full     (rob_full),
        .rob_tail     (rob_tail),
        .rob_done     (rob_done),
        .rob_value    (rob_value),
        .cdb          (cdb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    register_file u_regs (
        .clock        (clock),
        .rst_n        (rst_n),
        .src_idx      ({in_uop.src2, in_uop.src1}),
        .src_value    (src_value),
        .src_busy     (src_busy),
        .src_tag      (src_tag),
        .rename_en    (alloc),
        .rename_idx   (alloc_dest),
        .rename_tag   (rob_tail),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// File: ooo_pkg.sv
package ooo_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int xlen        = 32;
    localparam int reg_num     = 8;
    localparam int reg_idx_w   = 3;
    localparam int rob_size    = 8;
    localparam int rob_tag_w   = 3;
    localparam int rs_depth    = 2;
    localparam int mult_stages = 3;

    typedef logic [xlen-1:0]      data_t;
    typedef logic [rob_tag_w-1:0] rob_tag_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sltu,
        op_mul
    } op_e;

    // decoded micro-op from the front end
    typedef struct packed {
        op_e      op;
        reg_idx_t dest;
        reg_idx_t src1;
        reg_idx_t src2;
        data_t    imm;
        logic     use_imm;
    } uop_t;

    //////////////////////////////////////////////////////////////////////
    // operand word: a value once ready, the producer tag until then
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [xlen-rob_tag_w-1:0] pad;
        rob_tag_t                  tag;
    } pending_t;

    typedef union packed {
        data_t    value;
        pending_t pending;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u word;
    } operand_t;

    // station slot, also what goes to a unit
    typedef struct packed {
        op_e      op;
        rob_tag_t tag;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } cdb_t;

    typedef struct packed {
        rob_tag_t tag;
        reg_idx_t dest;
        data_t    value;
    } commit_t;

endpackage

// File: register_file.sv
`timescale 1ns/1ps

module register_file
    import ooo_pkg::*;
(
    input  logic           clock,
    input  logic           rst_n,
    input  reg_idx_t [1:0] src_idx,
    output data_t [1:0]    src_value,
    output logic [1:0]     src_busy,
    output rob_tag_t [1:0] src_tag,
    input  logic           rename_en,
    input  reg_idx_t       rename_idx,
    input  rob_tag_t       rename_tag,
    input  logic           commit_valid,
    input  commit_t        commit
);

    data_t [reg_num-1:0]    value_q;
    logic [reg_num-1:0]     busy_q;
    rob_tag_t [reg_num-1:0] tag_q;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_value[i] = value_q[src_idx[i]];
            src_busy[i]  = busy_q[src_idx[i]];
            src_tag[i]   = tag_q[src_idx[i]];
        end
    end

    // architectural state comes up as zero
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            value_q <= '0;
            busy_q  <= '0;
        end else begin
            if (commit_valid) begin
                value_q[commit.dest] <= commit.value;
                // a newer producer keeps the register busy
                if (tag_q[commit.dest] == commit.tag) begin
                    busy_q[commit.dest] <= 1'b0;
                end
            end
            // later assignment, so rename beats the clear
            if (rename_en) begin
                busy_q[rename_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rename_en) begin
            tag_q[rename_idx] <= rename_tag;
        end
    end

endmodule

// File: reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 alloc,
    input  reg_idx_t             alloc_dest,
    output logic                 rob_full,
    output rob_tag_t             rob_tail,
    output logic [rob_size-1:0]  rob_done,
    output data_t [rob_size-1:0] rob_value,
    input  cdb_t                 cdb,
    output logic                 commit_valid,
    output commit_t              commit
);

    rob_tag_t                head_q;
    rob_tag_t                tail_q;
    logic [rob_tag_w:0]      count_q;
    logic [rob_size-1:0]     done_q;
    reg_idx_t [rob_size-1:0] dest_q;
    data_t [rob_size-1:0]    value_q;

    assign rob_full  = (count_q == (rob_tag_w + 1)'(rob_size));
    assign rob_tail  = tail_q;
    assign rob_done  = done_q;
    assign rob_value = value_q;

    // head retires as soon as its result is in
    assign commit_valid = (count_q != '0) && done_q[head_q];
    assign commit.tag   = head_q;
    assign commit.dest  = dest_q[head_q];
    assign commit.value = value_q[head_q];

    //////////////////////////////////////////////////////////////////////
    // pointers and done bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            // tags wrap with the index width
            if (alloc) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            if (cdb.valid) begin
                done_q[cdb.tag] <= 1'b1;
            end
            if (commit_valid) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc, commit_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (alloc) begin
            dest_q[tail_q] <= alloc_dest;
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
        end
    end

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps

module reservation_station
    import ooo_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      load,
    input  rs_entry_t entry_in,
    output logic      full,
    input  cdb_t      cdb,
    output logic      issue_valid,
    output rs_entry_t issue,
    input  logic      issue_ready
);

    // slot 0 is the oldest, valid slots stay packed at the low end
    rs_entry_t [rs_depth-1:0] slot_q;
    rs_entry_t [rs_depth-1:0] woken;
    rs_entry_t [rs_depth-1:0] slot_d;
    logic [rs_depth-1:0]      valid_q;
    logic [rs_depth-1:0]      valid_d;
    logic [rs_depth-1:0]      can_go;
    int unsigned              issue_idx;
    logic                     take;

    function automatic operand_t wake(input operand_t o, input cdb_t bus);
        operand_t r;
        r = o;
        if (!o.ready && bus.valid && bus.tag == o.word.pending.tag) begin
            r.ready      = 1'b1;
            r.word.value = bus.value;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // wakeup and oldest-ready select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = 0;
        for (int i = 0; i < rs_depth; i++) begin
            woken[i]      = slot_q[i];
            woken[i].src1 = wake(slot_q[i].src1, cdb);
            woken[i].src2 = wake(slot_q[i].src2, cdb);
            can_go[i]     = valid_q[i] && woken[i].src1.ready && woken[i].src2.ready;
        end
        // first hit from the old end wins
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (can_go[i]) begin
                issue_valid = 1'b1;
                issue_idx   = i;
            end
        end
    end

    assign issue = woken[issue_idx];
    assign take  = issue_valid && issue_ready;
    assign full  = valid_q[rs_depth-1];

    //////////////////////////////////////////////////////////////////////
    // compaction and load
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        int unsigned k;
        k       = 0;
        valid_d = '0;
        slot_d  = woken;
        for (int i = 0; i < rs_depth; i++) begin
            if (valid_q[i] && !(take && issue_idx == i)) begin
                slot_d[k]  = woken[i];
                valid_d[k] = 1'b1;
                k++;
            end
        end
        if (load && k < rs_depth) begin
            slot_d[k]  = entry_in;
            valid_d[k] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clock) begin
        slot_q <= slot_d;
    end

endmodule

// File: tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core
    import ooo_pkg::*;
();

    // one stimulus row where burst rows go out with no idle gap
    typedef struct packed {
        logic [7:0] test_id;
        logic       burst;
        uop_t       uop;
    } row_t;

    typedef struct packed {
        logic [7:0] test_id;
        commit_t    c;
    } expect_t;

    logic    clock = 1'b0;
    logic    rst_n;
    logic    in_valid;
    uop_t    in_uop;
    logic    in_ready;
    logic    commit_valid;
    commit_t commit;

    row_t    rows[$];
    expect_t expected[$];
    data_t   model_regs [reg_num];
    int      rows_left [1:6];
    int      test_fails [1:6];
    int      accepted;
    int      commits_seen;
    int      checks_passed;
    int      checks_failed;
    int      cycles;
    int      cycle_limit;
    logic    stall_seen;

    ooo_core u_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_uop       (in_uop),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #5 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic data_t reference_result(input op_e op, input data_t a, input data_t b);
        logic [63:0] full;
        data_t       r;
        full = 64'(a) * 64'(b);
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_sltu: r = (a < b) ? 32'd1 : 32'd0;
            // low word of the product only
            op_mul:  r = full[31:0];
            default: r = '0;
        endcase
        return r;
    endfunction

    // in-order execution with tags in acceptance order
    task automatic predict_commit(input row_t r);
        data_t   a;
        data_t   b;
        expect_t e;
        a = model_regs[r.uop.src1];
        b = r.uop.use_imm ? r.uop.imm : model_regs[r.uop.src2];
        e.test_id = r.test_id;
        e.c.tag   = rob_tag_t'(accepted % rob_size);
        e.c.dest  = r.uop.dest;
        e.c.value = reference_result(r.uop.op, a, b);
        model_regs[r.uop.dest] = e.c.value;
        expected.push_back(e);
        accepted++;
    endtask

    task automatic add_row(input int test_id, input op_e op, input int dest, input int src1,
                           input int src2, input data_t imm, input logic use_imm,
                           input logic burst);
        row_t r;
        r.test_id     = 8'(test_id);
        r.burst       = burst;
        r.uop.op      = op;
        r.uop.dest    = reg_idx_t'(dest);
        r.uop.src1    = reg_idx_t'(src1);
        r.uop.src2    = reg_idx_t'(src2);
        r.uop.imm     = imm;
        r.uop.use_imm = use_imm;
        rows.push_back(r);
        rows_left[test_id]++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks and reporting
    //////////////////////////////////////////////////////////////////////

    task automatic compare_field(input int test_id, input string name, input data_t got,
                                 input data_t exp);
        assert (got === exp) checks_passed++;
        else begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            checks_failed++;
            test_fails[test_id]++;
        end
    endtask

    task automatic report_test(input int test_id);
        if (test_id == 6) begin
            assert (stall_seen) checks_passed++;
            else begin
                $display("in_ready never dropped during the multiply burst");
                checks_failed++;
                test_fails[6]++;
            end
        end
        $display("test %0d finished with %0d mismatches", test_id, test_fails[test_id]);
    endtask

    // commit is stable mid-cycle
    always @(negedge clock) begin
        expect_t e;
        if (rst_n && commit_valid) begin
            commits_seen++;
            assert (expected.size() > 0) checks_passed++;
            else begin
                $display("a commit arrived at %0t with no accepted op waiting for it", $time);
                checks_failed++;
            end
            if (expected.size() > 0) begin
                e = expected.pop_front();
                compare_field(e.test_id, "commit.tag", 32'(commit.tag), 32'(e.c.tag));
                compare_field(e.test_id, "commit.dest", 32'(commit.dest), 32'(e.c.dest));
                compare_field(e.test_id, "commit.value", commit.value, e.c.value);
                rows_left[e.test_id]--;
                if (rows_left[e.test_id] == 0) begin
                    report_test(e.test_id);
                end
            end
        end
    end

    // run limit scales with the table
    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d commits seen",
                     cycles, commits_seen, rows.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // entered at a falling edge and returns at the falling edge after acceptance
    task automatic send_uop(input row_t r);
        int   gap;
        logic taken;
        gap = r.burst ? 0 : int'($urandom % 3);
        if (gap > 0) begin
            in_valid = 1'b0;
            repeat (gap) @(negedge clock);
        end
        in_valid = 1'b1;
        in_uop   = r.uop;
        taken    = 1'b0;
        while (!taken) begin
            // in_ready settles after the edge and holds until the next rise
            #1;
            taken = in_ready;
            if (!taken && r.burst) begin
                stall_seen = 1'b1;
            end
            if (taken) begin
                predict_commit(r);
            end
            @(negedge clock);
        end
    endtask

    task automatic build_table();
        // test 1 reads never-written registers as zero
        add_row(1, op_add, 1, 2, 3, 32'h0, 1'b0, 1'b0);
        add_row(1, op_or, 2, 6, 0, 32'h0000_00a5, 1'b1, 1'b0);
        // test 2 mixes register and immediate sources
        add_row(2, op_add, 3, 0, 0, 32'h7fff_fff0, 1'b1, 1'b0);
        add_row(2, op_add, 4, 0, 0, 32'h0000_0025, 1'b1, 1'b0);
        add_row(2, op_sub, 5, 0, 0, 32'h0000_0001, 1'b1, 1'b0);
        add_row(2, op_and, 6, 2, 0, 32'h0f0f_0f0f, 1'b1, 1'b0);
        add_row(2, op_xor, 7, 2, 0, 32'hffff_0000, 1'b1, 1'b0);
        add_row(2, op_sltu, 1, 2, 5, 32'h0, 1'b0, 1'b0);
        // test 3 runs read-after-write chains
        add_row(3, op_add, 1, 3, 4, 32'h0, 1'b0, 1'b0);
        add_row(3, op_sub, 2, 1, 4, 32'h0, 1'b0, 1'b0);
        add_row(3, op_add, 1, 1, 2, 32'h0, 1'b0, 1'b0);
        add_row(3, op_sltu, 6, 2, 1, 32'h0, 1'b0, 1'b0);
        add_row(3, op_or, 7, 6, 1, 32'h0, 1'b0, 1'b0);
        // test 4 puts a slow multiply ahead of independent adds
        add_row(4, op_mul, 5, 3, 4, 32'h0, 1'b0, 1'b0);
        add_row(4, op_add, 6, 0, 0, 32'd11, 1'b1, 1'b0);
        add_row(4, op_add, 7, 0, 0, 32'd22, 1'b1, 1'b0);
        add_row(4, op_add, 2, 5, 0, 32'd1, 1'b1, 1'b0);
        // test 5 writes r3 fast then slow so the older commit lands first
        add_row(5, op_add, 3, 0, 0, 32'h0000_0222, 1'b1, 1'b0);
        add_row(5, op_mul, 3, 4, 0, 32'd3, 1'b1, 1'b0);
        add_row(5, op_add, 4, 3, 0, 32'h0, 1'b1, 1'b0);
        add_row(5, op_add, 5, 3, 0, 32'h1, 1'b1, 1'b0);
        // test 6 is a dependent multiply burst longer than the ROB
        add_row(6, op_add, 1, 0, 0, 32'd3, 1'b1, 1'b1);
        for (int i = 0; i < 10; i++) begin
            add_row(6, op_mul, 1, 1, 0, 32'h9e37_79b9, 1'b1, 1'b1);
        end
    endtask

    initial begin
        void'($urandom(60413));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_uop     = '0;
        stall_seen = 1'b0;
        for (int i = 0; i < reg_num; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        cycle_limit = rows.size() * (rob_size + mult_stages + 4) + 200;

        repeat (10) @(negedge clock);
        rst_n = 1'b1;
        #1;
        compare_field(1, "in_ready", 32'(in_ready), 32'd1);
        compare_field(1, "commit_valid", 32'(commit_valid), 32'd0);
        @(negedge clock);

        foreach (rows[i]) begin
            send_uop(rows[i]);
        end
        in_valid = 1'b0;

        // drain and wait a few more cycles for any stray commit
        while (commits_seen < rows.size()) begin
            @(negedge clock);
        end
        repeat (rob_size + mult_stages) @(negedge clock);
        assert (commits_seen == rows.size()) checks_passed++;
        else begin
            $display("FAIL %0t commit count got %0d expected %0d",
                     $time, commits_seen, rows.size());
            checks_failed++;
        end

        $display("checks passed %0d, failed %0d", checks_passed, checks_failed);
        if (checks_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
